// ==== hw/vdp_pkg.sv ====
package vdp_pkg;

    // beat geometry
    localparam int LANES      = 4;
    localparam int LANE_W     = 32;
    localparam int LANE_BYTES = LANE_W / 8;   // keep bits per lane
    localparam int MAX_VREGS  = 8;            // entries per column register file

    typedef logic [LANE_W-1:0]             lane_t;
    typedef logic [LANES*LANE_W-1:0]       vec_t;
    typedef logic [LANES-1:0]              lane_mask_t;
    typedef logic [LANES*LANE_BYTES-1:0]   keep_t;
    typedef logic [$clog2(MAX_VREGS)-1:0]  vreg_addr_t;
    typedef logic [$clog2(MAX_VREGS):0]    vlen_t;     // 1 .. MAX_VREGS

    // one beat as it travels between the stages
    typedef struct packed {
        vec_t       data;
        lane_mask_t lane_vld;   // lane carries valid data
        logic       last;       // final beat of the packet
    } beat_t;

    // register file write from the configuration port
    typedef struct packed {
        logic       we;
        logic [7:0] col;        // target column
        vreg_addr_t addr;
        vec_t       weight;
        vec_t       bias;
    } cfg_wr_t;

    typedef enum logic {
        RUN_IDLE   = 1'b0,
        RUN_ACTIVE = 1'b1
    } run_state_e;

endpackage

// ==== hw/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
    parameter int DEPTH = 16
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           i_push,
    input  logic           i_pop,
    input  vdp_pkg::beat_t i_din,
    output vdp_pkg::beat_t o_dout,
    output logic           o_empty,
    output logic           o_full
);
    import vdp_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    beat_t            mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_pop  = i_pop && !o_empty;
    assign do_push = i_push && (!o_full || do_pop);   // full fifo still takes push with pop
    assign o_empty = (count == '0);
    assign o_full  = (count == CNT_W'(DEPTH));
    assign o_dout  = mem[rd_ptr];                     // head always visible

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;       // idle or push with pop
            endcase
        end
    end

endmodule

// ==== hw/stream_in_stage.sv ====
`timescale 1ns/1ps

module stream_in_stage #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic           clk,
    input  logic           rst,
    // input stream
    input  vdp_pkg::vec_t  i_tdata,
    input  vdp_pkg::keep_t i_tkeep,
    input  logic           i_tlast,
    input  logic           i_tvalid,
    output logic           o_tready,
    input  logic           i_active,   // run is open
    // beat channel to the first column
    output vdp_pkg::beat_t o_beat,
    output logic           o_valid,
    input  logic           i_ready
);
    import vdp_pkg::*;

    lane_mask_t lane_vld;
    beat_t      in_beat;
    logic       fifo_empty;
    logic       fifo_full;
    logic       push;
    logic       pop;

    // a lane counts only with all four keep bits set
    for (genvar l = 0; l < LANES; l++) begin : g_lane_vld
        assign lane_vld[l] = &i_tkeep[l*LANE_BYTES +: LANE_BYTES];
    end

    assign in_beat.data     = i_tdata;
    assign in_beat.lane_vld = lane_vld;
    assign in_beat.last     = i_tlast;

    assign o_tready = i_active && !fifo_full;
    assign push     = i_tvalid && o_tready;
    assign o_valid  = !fifo_empty;
    assign pop      = o_valid && i_ready;

    sync_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk     (clk),
        .rst     (rst),
        .i_push  (push),
        .i_pop   (pop),
        .i_din   (in_beat),
        .o_dout  (o_beat),
        .o_empty (fifo_empty),
        .o_full  (fifo_full)
    );

endmodule

// ==== hw/vec_reg_file.sv ====
`timescale 1ns/1ps

module vec_reg_file (
    input  logic                clk,
    input  logic                i_we,
    input  vdp_pkg::vreg_addr_t i_waddr,
    input  vdp_pkg::vreg_addr_t i_raddr,
    input  vdp_pkg::vec_t       i_wweight,
    input  vdp_pkg::vec_t       i_wbias,
    output vdp_pkg::vec_t       o_weight,
    output vdp_pkg::vec_t       o_bias
);
    import vdp_pkg::*;

    // separate weight and bias banks, same address
    vec_t weight_mem [MAX_VREGS];
    vec_t bias_mem   [MAX_VREGS];

    always_ff @(posedge clk) begin
        if (i_we) begin
            weight_mem[i_waddr] <= i_wweight;
            bias_mem[i_waddr]   <= i_wbias;
        end
    end

    // combinational read for the multiply-add in the same cycle
    assign o_weight = weight_mem[i_raddr];
    assign o_bias   = bias_mem[i_raddr];

endmodule

// ==== hw/vec_mac_column.sv ====
`timescale 1ns/1ps

module vec_mac_column #(
    parameter int COL_IDX = 0
) (
    input  logic             clk,
    input  logic             rst,
    // configuration port, shared by all columns
    input  vdp_pkg::cfg_wr_t i_cfg,
    input  vdp_pkg::vlen_t   i_vlen,
    // upstream beat channel
    input  vdp_pkg::beat_t   i_beat,
    input  logic             i_valid,
    output logic             o_ready,
    // downstream beat channel
    output vdp_pkg::beat_t   o_beat,
    output logic             o_valid,
    input  logic             i_ready
);
    import vdp_pkg::*;

    vreg_addr_t addr;          // auto-incrementing register address
    vec_t       weight;
    vec_t       bias;
    vec_t       mac_data;
    logic       col_we;
    logic       accept;
    logic       addr_wrap;
    beat_t      stage_beat;
    logic       stage_vld;

    assign col_we = i_cfg.we && (i_cfg.col == 8'(COL_IDX));

    vec_reg_file u_rf (
        .clk       (clk),
        .i_we      (col_we),
        .i_waddr   (i_cfg.addr),
        .i_raddr   (addr),
        .i_wweight (i_cfg.weight),
        .i_wbias   (i_cfg.bias),
        .o_weight  (weight),
        .o_bias    (bias)
    );

    // per lane in * weight + bias, mod 2^32
    for (genvar l = 0; l < LANES; l++) begin : g_lane
        lane_t a;
        lane_t w;
        lane_t b;

        assign a = i_beat.data[l*LANE_W +: LANE_W];
        assign w = weight[l*LANE_W +: LANE_W];
        assign b = bias[l*LANE_W +: LANE_W];
        assign mac_data[l*LANE_W +: LANE_W] = i_beat.lane_vld[l] ? a * w + b : '0;
    end

    // stage takes a beat when empty or when its own beat leaves now
    assign o_ready   = !stage_vld || i_ready;
    assign accept    = i_valid && o_ready;
    assign addr_wrap = i_beat.last || (vlen_t'(addr) == i_vlen - vlen_t'(1));

    always_ff @(posedge clk) begin
        if (rst) begin
            addr <= '0;
        end else if (accept) begin
            addr <= addr_wrap ? '0 : addr + 1'b1;   // last beat rewinds for the next packet
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_vld <= 1'b0;
        end else if (accept) begin
            stage_vld <= 1'b1;
        end else if (i_ready) begin
            stage_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            stage_beat.data     <= mac_data;
            stage_beat.lane_vld <= i_beat.lane_vld;
            stage_beat.last     <= i_beat.last;
        end
    end

    assign o_beat  = stage_beat;
    assign o_valid = stage_vld;

endmodule

// ==== hw/stream_out_stage.sv ====
`timescale 1ns/1ps

module stream_out_stage #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic           clk,
    input  logic           rst,
    // beat channel from the last column
    input  vdp_pkg::beat_t i_beat,
    input  logic           i_valid,
    output logic           o_ready,
    // output stream
    output vdp_pkg::vec_t  o_tdata,
    output vdp_pkg::keep_t o_tkeep,
    output logic           o_tlast,
    output logic           o_tvalid,
    input  logic           i_tready,
    output logic           o_done
);
    import vdp_pkg::*;

    beat_t head;
    logic  fifo_empty;
    logic  fifo_full;
    logic  push;
    logic  pop;

    assign o_ready  = !fifo_full;
    assign push     = i_valid && o_ready;
    assign o_tvalid = !fifo_empty;
    assign pop      = o_tvalid && i_tready;

    sync_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk     (clk),
        .rst     (rst),
        .i_push  (push),
        .i_pop   (pop),
        .i_din   (i_beat),
        .o_dout  (head),
        .o_empty (fifo_empty),
        .o_full  (fifo_full)
    );

    // each lane flag back out as four keep bits
    for (genvar l = 0; l < LANES; l++) begin : g_keep
        assign o_tkeep[l*LANE_BYTES +: LANE_BYTES] = {LANE_BYTES{head.lane_vld[l]}};
    end

    assign o_tdata = head.data;
    assign o_tlast = head.last;
    assign o_done  = pop && head.last;   // handshake of the final beat

endmodule

// ==== hw/vec_datapath.sv ====
`timescale 1ns/1ps

module vec_datapath #(
    parameter int NUM_COL    = 2,
    parameter int FIFO_DEPTH = 16
) (
    input  logic             clk,
    input  logic             rst,
    // run control
    input  logic             i_start,
    output logic             o_done,
    // configuration
    input  vdp_pkg::cfg_wr_t i_cfg,
    input  vdp_pkg::vlen_t   i_vlen,   // change only while idle
    // input stream
    input  vdp_pkg::vec_t    i_s_tdata,
    input  vdp_pkg::keep_t   i_s_tkeep,
    input  logic             i_s_tlast,
    input  logic             i_s_tvalid,
    output logic             o_s_tready,
    // output stream
    output vdp_pkg::vec_t    o_m_tdata,
    output vdp_pkg::keep_t   o_m_tkeep,
    output logic             o_m_tlast,
    output logic             o_m_tvalid,
    input  logic             i_m_tready
);
    import vdp_pkg::*;

    run_state_e       state;
    run_state_e       state_next;
    logic             run_active;

    // beat channels, index k feeds column k
    beat_t            chain_beat [NUM_COL+1];
    logic [NUM_COL:0] chain_valid;
    logic [NUM_COL:0] chain_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RUN_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            RUN_IDLE:   if (i_start) state_next = RUN_ACTIVE;
            RUN_ACTIVE: if (o_done) state_next = RUN_IDLE;   // start ignored here
            default:    state_next = RUN_IDLE;
        endcase
    end

    assign run_active = (state == RUN_ACTIVE);

    stream_in_stage #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_stream_in (
        .clk      (clk),
        .rst      (rst),
        .i_tdata  (i_s_tdata),
        .i_tkeep  (i_s_tkeep),
        .i_tlast  (i_s_tlast),
        .i_tvalid (i_s_tvalid),
        .o_tready (o_s_tready),
        .i_active (run_active),
        .o_beat   (chain_beat[0]),
        .o_valid  (chain_valid[0]),
        .i_ready  (chain_ready[0])
    );

    for (genvar k = 0; k < NUM_COL; k++) begin : g_col
        vec_mac_column #(
            .COL_IDX (k)
        ) u_col (
            .clk     (clk),
            .rst     (rst),
            .i_cfg   (i_cfg),
            .i_vlen  (i_vlen),
            .i_beat  (chain_beat[k]),
            .i_valid (chain_valid[k]),
            .o_ready (chain_ready[k]),
            .o_beat  (chain_beat[k+1]),
            .o_valid (chain_valid[k+1]),
            .i_ready (chain_ready[k+1])
        );
    end

    stream_out_stage #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_stream_out (
        .clk      (clk),
        .rst      (rst),
        .i_beat   (chain_beat[NUM_COL]),
        .i_valid  (chain_valid[NUM_COL]),
        .o_ready  (chain_ready[NUM_COL]),
        .o_tdata  (o_m_tdata),
        .o_tkeep  (o_m_tkeep),
        .o_tlast  (o_m_tlast),
        .o_tvalid (o_m_tvalid),
        .i_tready (i_m_tready),
        .o_done   (o_done)
    );

endmodule

// ==== testbench/tb_vec_datapath.sv ====
`timescale 1ns/1ps

module tb_vec_datapath;
    import vdp_pkg::*;

    localparam int NUM_COL    = 2;
    localparam int FIFO_DEPTH = 4;   // small so a stalled output reaches the input
    localparam int NUM_ROWS   = 40;
    localparam int NUM_PKT    = 5;

    // one stimulus row with its expected output
    typedef struct packed {
        vec_t  data;
        keep_t keep;
        logic  last;
        vec_t  exp_data;
        keep_t exp_keep;
    } row_t;

    logic     clk = 1'b0;
    logic     rst;
    logic     i_start;
    logic     o_done;
    cfg_wr_t  i_cfg;
    vlen_t    i_vlen;
    vec_t     i_s_tdata;
    keep_t    i_s_tkeep;
    logic     i_s_tlast;
    logic     i_s_tvalid;
    logic     o_s_tready;
    vec_t     o_m_tdata;
    keep_t    o_m_tkeep;
    logic     o_m_tlast;
    logic     o_m_tvalid;
    logic     i_m_tready;

    lane_t    ref_w [NUM_COL][MAX_VREGS][LANES];   // testbench copy of the weights
    lane_t    ref_b [NUM_COL][MAX_VREGS][LANES];
    row_t     rows [NUM_ROWS];
    int       pkt_vlen [NUM_PKT];
    bit       pkt_bp [NUM_PKT];
    int       pkt_first [NUM_PKT];
    int       pkt_len [NUM_PKT];
    int       row_cnt = 0;
    int       pkt_cnt = 0;
    bit       bp_mode = 1'b0;
    integer   seed = 67041;

    vec_datapath #(
        .NUM_COL    (NUM_COL),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_dut (
        .clk        (clk),
        .rst        (rst),
        .i_start    (i_start),
        .o_done     (o_done),
        .i_cfg      (i_cfg),
        .i_vlen     (i_vlen),
        .i_s_tdata  (i_s_tdata),
        .i_s_tkeep  (i_s_tkeep),
        .i_s_tlast  (i_s_tlast),
        .i_s_tvalid (i_s_tvalid),
        .o_s_tready (o_s_tready),
        .o_m_tdata  (o_m_tdata),
        .o_m_tkeep  (o_m_tkeep),
        .o_m_tlast  (o_m_tlast),
        .o_m_tvalid (o_m_tvalid),
        .i_m_tready (i_m_tready)
    );

    always #5 clk = ~clk;

    // output side ready, random only in back-pressure packets
    always @(posedge clk) begin
        #1;
        i_m_tready = bp_mode ? 1'($random(seed)) : 1'b1;
    end

    initial begin
        repeat (200 * NUM_ROWS + 1000) @(posedge clk);
        $display("timeout: the DUT did not finish all packets in time");
        $display("RESULT: FAIL");
        $fatal(1);
    end

    task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    function automatic lane_t ref_lane(input lane_t din, input int addr, input int lane);
        lane_t v;
        v = din;
        for (int c = 0; c < NUM_COL; c++) begin
            v = v * ref_w[c][addr][lane] + ref_b[c][addr][lane];   // wraps at 2^32
        end
        return v;
    endfunction

    task automatic fill_coeffs();
        for (int c = 0; c < NUM_COL; c++) begin
            for (int a = 0; a < MAX_VREGS; a++) begin
                for (int l = 0; l < LANES; l++) begin
                    ref_w[c][a][l] = 32'h0001_0003 * 32'(c * 32 + a * 4 + l + 1);
                    ref_b[c][a][l] = 32'ha5a5_0000 ^ 32'((c << 12) | (a << 6) | (l << 1) | 1);
                end
            end
        end
    endtask

    task automatic start_packet(input int vlen, input bit bp);
        pkt_vlen[pkt_cnt]  = vlen;
        pkt_bp[pkt_cnt]    = bp;
        pkt_first[pkt_cnt] = row_cnt;
        pkt_len[pkt_cnt]   = 0;
        pkt_cnt++;
    endtask

    task automatic add_row(input vec_t data, input keep_t keep, input logic last);
        row_t r;
        int   p;
        int   addr;
        p    = pkt_cnt - 1;
        addr = pkt_len[p] % pkt_vlen[p];   // beat index wraps at vlen
        r    = '0;
        r.data = data;
        r.keep = keep;
        r.last = last;
        for (int l = 0; l < LANES; l++) begin
            if (&keep[l*LANE_BYTES +: LANE_BYTES]) begin
                r.exp_data[l*LANE_W +: LANE_W] = ref_lane(data[l*LANE_W +: LANE_W], addr, l);
                r.exp_keep[l*LANE_BYTES +: LANE_BYTES] = '1;
            end
        end
        rows[row_cnt] = r;
        row_cnt++;
        pkt_len[p]++;
    endtask

    task automatic build_table();
        vec_t d;
        // single address, values near the wrap
        start_packet(1, 1'b0);
        add_row({32'hffff_ffff, 32'h8000_0001, 32'h0000_0000, 32'h0000_0001}, '1, 1'b0);
        add_row({32'h1234_5678, 32'h9abc_def0, 32'h0f0f_0f0f, 32'hdead_beef}, '1, 1'b0);
        add_row({32'h7fff_ffff, 32'h0000_0003, 32'hcafe_f00d, 32'h0000_00ff}, '1, 1'b1);
        // vlen 3 over seven beats, then a new packet from address 0
        start_packet(3, 1'b0);
        for (int i = 0; i < 7; i++) begin
            d = {32'(i) + 32'h3000, 32'(i) + 32'h2000, 32'(i) + 32'h1000, 32'(i)};
            add_row(d, '1, i == 6);
        end
        start_packet(3, 1'b0);
        add_row({32'h0000_0011, 32'h0000_0022, 32'h0000_0033, 32'h0000_0044}, '1, 1'b0);
        add_row({32'h0000_0055, 32'h0000_0066, 32'h0000_0077, 32'h0000_0088}, '1, 1'b1);
        // partial and cleared keep nibbles
        start_packet(2, 1'b0);
        add_row({32'h1111_1111, 32'h2222_2222, 32'h3333_3333, 32'h4444_4444}, 16'hfff0, 1'b0);
        add_row({32'h5555_5555, 32'h6666_6666, 32'h7777_7777, 32'h8888_8888}, 16'h0f7f, 1'b0);
        add_row({32'h9999_9999, 32'haaaa_aaaa, 32'hbbbb_bbbb, 32'hcccc_cccc}, 16'h0000, 1'b0);
        add_row({32'hdddd_dddd, 32'heeee_eeee, 32'hffff_ffff, 32'h0101_0101}, 16'hf0ff, 1'b1);
        // random data under random output ready
        start_packet(8, 1'b1);
        for (int i = 0; i < 24; i++) begin
            d = {$random(seed), $random(seed), $random(seed), $random(seed)};
            add_row(d, (i % 5 == 2) ? 16'hff0f : 16'hffff, i == 23);
        end
    endtask

    task automatic write_vregs();
        cfg_wr_t cfg;
        for (int c = 0; c < NUM_COL; c++) begin
            for (int a = 0; a < MAX_VREGS; a++) begin
                cfg      = '0;
                cfg.we   = 1'b1;
                cfg.col  = 8'(c);
                cfg.addr = vreg_addr_t'(a);
                for (int l = 0; l < LANES; l++) begin
                    cfg.weight[l*LANE_W +: LANE_W] = ref_w[c][a][l];
                    cfg.bias[l*LANE_W +: LANE_W]   = ref_b[c][a][l];
                end
                i_cfg = cfg;
                @(posedge clk);
                #1;
            end
        end
        i_cfg = '0;
    endtask

    task automatic send_rows(input int p);
        for (int i = pkt_first[p]; i < pkt_first[p] + pkt_len[p]; i++) begin
            i_s_tdata  = rows[i].data;
            i_s_tkeep  = rows[i].keep;
            i_s_tlast  = rows[i].last;
            i_s_tvalid = 1'b1;
            do @(negedge clk); while (!o_s_tready);
            @(posedge clk);
            #1;
        end
        i_s_tvalid = 1'b0;
    endtask

    task automatic collect_rows(input int p);
        int n;
        int i;
        n = 0;
        while (n < pkt_len[p]) begin
            @(negedge clk);
            if (o_m_tvalid && i_m_tready) begin
                i = pkt_first[p] + n;
                check("o_m_tdata", o_m_tdata, rows[i].exp_data);
                check("o_m_tkeep", o_m_tkeep, rows[i].exp_keep);
                check("o_m_tlast", o_m_tlast, rows[i].last);
                check("o_done", o_done, rows[i].last);   // only on the last handshake
                n++;
            end else begin
                check("o_done", o_done, 1'b0);
            end
        end
        // input stays closed until the next start, nothing left behind
        repeat (3) begin
            @(negedge clk);
            check("o_s_tready", o_s_tready, 1'b0);
            check("o_done", o_done, 1'b0);
            check("o_m_tvalid", o_m_tvalid, 1'b0);
        end
    endtask

    task automatic run_packet(input int p);
        @(posedge clk);
        #1;
        i_vlen  = vlen_t'(pkt_vlen[p]);
        bp_mode = pkt_bp[p];
        repeat (2) begin
            @(negedge clk);
            check("o_s_tready", o_s_tready, 1'b0);
        end
        @(posedge clk);
        #1;
        i_start = 1'b1;
        @(posedge clk);
        #1;
        i_start = 1'b0;
        @(negedge clk);
        check("o_s_tready", o_s_tready, 1'b1);
        @(posedge clk);
        #1;
        fork
            send_rows(p);
            collect_rows(p);
        join
    endtask

    initial begin
        rst        = 1'b1;
        i_start    = 1'b0;
        i_cfg      = '0;
        i_vlen     = vlen_t'(1);
        i_s_tdata  = '0;
        i_s_tkeep  = '0;
        i_s_tlast  = 1'b0;
        i_s_tvalid = 1'b0;
        i_m_tready = 1'b0;
        fill_coeffs();
        build_table();
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check("o_m_tvalid", o_m_tvalid, 1'b0);
        check("o_done", o_done, 1'b0);
        @(posedge clk);
        #1;
        write_vregs();
        for (int p = 0; p < NUM_PKT; p++) begin
            run_packet(p);
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== tb.f ====
hw/vdp_pkg.sv
hw/sync_fifo.sv
hw/stream_in_stage.sv
hw/vec_reg_file.sv
hw/vec_mac_column.sv
hw/stream_out_stage.sv
hw/vec_datapath.sv
testbench/tb_vec_datapath.sv

// ==== Bender.yml ====
package:
  name: vec_datapath

sources:
  - files:
      - hw/vdp_pkg.sv
      - hw/sync_fifo.sv
      - hw/stream_in_stage.sv
      - hw/vec_reg_file.sv
      - hw/vec_mac_column.sv
      - hw/stream_out_stage.sv
      - hw/vec_datapath.sv
  - target: test
    files:
      - testbench/tb_vec_datapath.sv
